//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=tb_soc_peripherals
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module "$TOP" \
  -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
  echo "simulation ended without the pass line"
  exit 1
fi
echo "simulation passed"
exit 0

//--- sim.f
src/soc_periph_pkg.sv
src/apb_periph_demux.sv
src/ref_clk_edge_sync.sv
src/apb_gpio.sv
src/apb_timer_unit.sv
src/apb_soc_ctrl.sv
src/soc_peripherals.sv
sim/tb_soc_peripherals.sv

//--- sim/tb_soc_peripherals.sv
// N_GPIO is fixed at 16 and all random data comes from one seed, so every run is the same
// timer COUNT is only compared while its tick source is known and quiet
`default_nettype none

module tb_soc_peripherals;

  import soc_periph_pkg::*;

  localparam int unsigned N_GPIO         = 16;
  localparam int          TIMEOUT_CYCLES = 5000;  // whole run is well under 1000 cycles
  localparam int          REF_PERIODS    = 6;     // ref clock periods in the timer test
  localparam int          REF_HALF       = 6;     // clk cycles per ref level

  typedef logic [APB_DATA_W:0] chk_t;  // {pslverr, prdata}

  logic              clk;
  logic              rst_n;
  logic              ref_clk;
  logic              stoptimer;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;
  logic [N_GPIO-1:0] apbio_in;
  logic [N_GPIO-1:0] apbio_out;
  logic [N_GPIO-1:0] apbio_oe;
  paddr_t            fc_bootaddr;
  logic              fc_fetchen;
  pdata_t            fc_events;

  // shadow registers
  paddr_t            sh_boot;
  logic              sh_fetchen;
  logic [N_GPIO-1:0] sh_dir;
  logic [N_GPIO-1:0] sh_out;
  logic [N_GPIO-1:0] sh_in;  // synced pad value
  logic [N_GPIO-1:0] sh_irq_en;
  logic [N_GPIO-1:0] sh_irq_status;
  logic [2:0]        sh_cfg;  // {clr_on_cmp, src_ref, en}
  pdata_t            sh_count;
  pdata_t            sh_cmp;

  // last bus response, handed to the checker
  event   rsp_seen;
  paddr_t rsp_addr;
  chk_t   rsp_got;
  chk_t   rsp_exp;

  int seed           = 32'h54b5b2fe;
  int cycle_cnt      = 0;
  int ref_rises      = 0;
  int ref_falls      = 0;
  int tmr_pulses     = 0;
  int tmr_alt_pulses = 0;

  soc_peripherals #(
    .N_GPIO (N_GPIO)
  ) u_soc_peripherals (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .ref_clk_i     (ref_clk),
    .stoptimer_i   (stoptimer),
    .apb_req_i     (apb_req),
    .apb_rsp_o     (apb_rsp),
    .apbio_in_i    (apbio_in),
    .apbio_out_o   (apbio_out),
    .apbio_oe_o    (apbio_oe),
    .fc_bootaddr_o (fc_bootaddr),
    .fc_fetchen_o  (fc_fetchen),
    .fc_events_o   (fc_events)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_eq(input string what, input chk_t got, input chk_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // every bus response is compared here
  always @(rsp_seen) begin
    check_eq($sformatf("response at %h", rsp_addr), rsp_got, rsp_exp);
  end

  // event vector watcher
  always @(negedge clk) begin
    if (fc_events[FC_EVT_REF_RISE]) ref_rises++;
    if (fc_events[FC_EVT_REF_FALL]) ref_falls++;
    if (fc_events[FC_EVT_TIMER_LO]) tmr_pulses++;
    if (fc_events[FC_EVT_TIMER_LO_ALT]) tmr_alt_pulses++;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic paddr_t reg_addr(input slv_idx_t idx, input reg_offs_t offs);
    return {18'h0, idx, offs};
  endfunction

  function automatic void clear_periph_shadow();
    sh_dir        = '0;  // gpio and timer only, soc control survives
    sh_out        = '0;
    sh_irq_en     = '0;
    sh_irq_status = '0;
    sh_cfg        = '0;
    sh_count      = '0;
    sh_cmp        = '0;
  endfunction

  function automatic void shadow_write(input paddr_t addr, input pdata_t data);
    reg_offs_t offs;
    offs = addr[SLV_SEL_LSB-1:0];
    case (addr[SLV_SEL_LSB +: 2])
      SLV_GPIO: begin
        if (offs == GPIO_DIR_OFFS)    sh_dir    = data[N_GPIO-1:0];
        if (offs == GPIO_OUT_OFFS)    sh_out    = data[N_GPIO-1:0];
        if (offs == GPIO_IRQ_EN_OFFS) sh_irq_en = data[N_GPIO-1:0];
      end
      SLV_TMR: begin
        if (offs == TMR_CFG_OFFS)   sh_cfg   = data[2:0];
        if (offs == TMR_COUNT_OFFS) sh_count = data;
        if (offs == TMR_CMP_OFFS)   sh_cmp   = data;
      end
      SLV_CTRL: begin
        if (offs == CTRL_BOOTADDR_OFFS) sh_boot    = data;
        if (offs == CTRL_FETCHEN_OFFS)  sh_fetchen = data[0];
        if (offs == CTRL_SOFT_RST_OFFS && data[0]) clear_periph_shadow();
      end
      default: ;  // hole drops writes
    endcase
  endfunction

  function automatic chk_t exp_read(input paddr_t addr);
    reg_offs_t offs;
    pdata_t    d;
    offs = addr[SLV_SEL_LSB-1:0];
    d    = '0;  // unknown offsets read 0
    case (addr[SLV_SEL_LSB +: 2])
      SLV_GPIO: begin
        case (offs)
          GPIO_DIR_OFFS:        d[N_GPIO-1:0] = sh_dir;
          GPIO_OUT_OFFS:        d[N_GPIO-1:0] = sh_out;
          GPIO_IN_OFFS:         d[N_GPIO-1:0] = sh_in;
          GPIO_IRQ_EN_OFFS:     d[N_GPIO-1:0] = sh_irq_en;
          GPIO_IRQ_STATUS_OFFS: d[N_GPIO-1:0] = sh_irq_status;
          default:              d = '0;
        endcase
      end
      SLV_TMR: begin
        case (offs)
          TMR_CFG_OFFS:   d[2:0] = sh_cfg;
          TMR_COUNT_OFFS: d = sh_count;
          TMR_CMP_OFFS:   d = sh_cmp;
          default:        d = '0;
        endcase
      end
      SLV_CTRL: begin
        case (offs)
          CTRL_BOOTADDR_OFFS: d = sh_boot;
          CTRL_FETCHEN_OFFS:  d[0] = sh_fetchen;
          CTRL_INFO_OFFS:     d = {16'h0, SOC_VERSION, 8'(N_GPIO)};  // version over pins
          default:            d = '0;
        endcase
      end
      default: return {1'b1, 32'h0};  // index 3
    endcase
    return {1'b0, d};
  endfunction

  //////////////////////////////////////////////////
  // bus driver, setup then access
  //////////////////////////////////////////////////
  task automatic apb_write(input paddr_t addr, input pdata_t data);
    logic hole;
    hole = (addr[SLV_SEL_LSB +: 2] == 2'd3);
    @(posedge clk);
    apb_req <= '{paddr: addr, pwdata: data, pwrite: 1'b1, psel: 1'b1, penable: 1'b0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rsp_addr = addr;
    rsp_exp  = {hole, 32'h0};  // write data only defined for the hole
    rsp_got  = {apb_rsp.pslverr, hole ? apb_rsp.prdata : 32'h0};
    -> rsp_seen;
    check_eq("pready", chk_t'(apb_rsp.pready), 33'h1);
    @(posedge clk);  // write lands here
    apb_req <= '0;
    shadow_write(addr, data);
  endtask

  task automatic apb_read(input paddr_t addr);
    @(posedge clk);
    apb_req <= '{paddr: addr, pwdata: '0, pwrite: 1'b0, psel: 1'b1, penable: 1'b0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);  // mid access cycle
    rsp_addr = addr;
    rsp_exp  = exp_read(addr);
    rsp_got  = {apb_rsp.pslverr, apb_rsp.prdata};
    -> rsp_seen;
    check_eq("pready", chk_t'(apb_rsp.pready), 33'h1);
    if (addr[SLV_SEL_LSB +: 2] == SLV_GPIO && addr[SLV_SEL_LSB-1:0] == GPIO_IRQ_STATUS_OFFS) begin
      sh_irq_status = '0;  // clear on read
    end
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic pins_match_shadow();
    @(negedge clk);
    check_eq("fc_bootaddr_o", chk_t'(fc_bootaddr), chk_t'(sh_boot));
    check_eq("fc_fetchen_o", chk_t'(fc_fetchen), chk_t'(sh_fetchen));
    check_eq("apbio_oe_o", chk_t'(apbio_oe), chk_t'(sh_dir));
    check_eq("apbio_out_o", chk_t'(apbio_out), chk_t'(sh_out));
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic boot_ctrl_readback();
    pdata_t rnd;
    rnd = $random(seed);
    apb_write(reg_addr(SLV_CTRL, CTRL_BOOTADDR_OFFS), rnd);
    rnd = $random(seed);
    apb_write(reg_addr(SLV_CTRL, CTRL_FETCHEN_OFFS), rnd | 32'h1);  // core must start
    pins_match_shadow();
    apb_read(reg_addr(SLV_CTRL, CTRL_BOOTADDR_OFFS));
    apb_read(reg_addr(SLV_CTRL, CTRL_FETCHEN_OFFS));
    apb_read(reg_addr(SLV_CTRL, CTRL_INFO_OFFS));
  endtask

  task automatic unmapped_access();
    pdata_t rnd;
    rnd = $random(seed);
    apb_write(reg_addr(2'd3, {rnd[11:2], 2'b00}), rnd);
    apb_read(reg_addr(2'd3, {rnd[11:2], 2'b00}));
    pins_match_shadow();  // nothing moved
    apb_read(reg_addr(SLV_GPIO, 12'h014));
    apb_read(reg_addr(SLV_TMR, 12'h00C));
    apb_read(reg_addr(SLV_CTRL, 12'h010));
    apb_read(reg_addr(SLV_CTRL, CTRL_SOFT_RST_OFFS));
  endtask

  task automatic gpio_pin_io();
    pdata_t rnd;
    rnd = $random(seed);
    apb_write(reg_addr(SLV_GPIO, GPIO_DIR_OFFS), rnd);
    rnd = $random(seed);
    apb_write(reg_addr(SLV_GPIO, GPIO_OUT_OFFS), rnd);
    pins_match_shadow();
    apb_read(reg_addr(SLV_GPIO, GPIO_DIR_OFFS));
    apb_read(reg_addr(SLV_GPIO, GPIO_OUT_OFFS));
    rnd = $random(seed);
    @(posedge clk);
    apbio_in <= rnd[N_GPIO-1:0];
    repeat (4) @(posedge clk);  // past the 2 sync flops
    sh_in = rnd[N_GPIO-1:0];
    apb_read(reg_addr(SLV_GPIO, GPIO_IN_OFFS));
  endtask

  task automatic gpio_edge_irq();
    pdata_t            rnd;
    logic [N_GPIO-1:0] en;
    logic [N_GPIO-1:0] pins;
    @(posedge clk);
    apbio_in <= '0;  // falling edges only, no status
    repeat (4) @(posedge clk);
    sh_in = '0;
    rnd = $random(seed);
    en  = {rnd[N_GPIO-1:1], 1'b1};
    apb_write(reg_addr(SLV_GPIO, GPIO_IRQ_EN_OFFS), pdata_t'(en));
    rnd  = $random(seed);
    pins = {rnd[N_GPIO-1:1], 1'b1};  // pin 0 always rises
    @(posedge clk);
    apbio_in <= pins;
    repeat (4) @(posedge clk);
    sh_in         = pins;
    sh_irq_status = pins & en;
    @(negedge clk);
    check_eq("gpio event set", chk_t'(fc_events[FC_EVT_GPIO]), 33'h1);
    apb_read(reg_addr(SLV_GPIO, GPIO_IRQ_EN_OFFS));
    apb_read(reg_addr(SLV_GPIO, GPIO_IRQ_STATUS_OFFS));
    @(negedge clk);
    check_eq("gpio event cleared", chk_t'(fc_events[FC_EVT_GPIO]), 33'h0);
    apb_read(reg_addr(SLV_GPIO, GPIO_IRQ_STATUS_OFFS));  // reads 0 now
  endtask

  task automatic timer_ref_and_cmp();
    int rises0;
    int falls0;
    int pulses0;
    int alt0;
    apb_write(reg_addr(SLV_TMR, TMR_COUNT_OFFS), 32'h0);
    apb_write(reg_addr(SLV_TMR, TMR_CFG_OFFS), 32'h3);  // enable, ref rises
    apb_read(reg_addr(SLV_TMR, TMR_CFG_OFFS));
    rises0 = ref_rises;
    falls0 = ref_falls;
    for (int i = 0; i < REF_PERIODS; i++) begin
      ref_clk <= 1'b1;
      repeat (REF_HALF) @(posedge clk);
      ref_clk <= 1'b0;
      repeat (REF_HALF) @(posedge clk);
    end
    sh_count = REF_PERIODS;
    @(negedge clk);
    check_eq("ref rise pulses", chk_t'(ref_rises - rises0), chk_t'(REF_PERIODS));
    check_eq("ref fall pulses", chk_t'(ref_falls - falls0), chk_t'(REF_PERIODS));
    apb_read(reg_addr(SLV_TMR, TMR_COUNT_OFFS));
    // freeze, then switch to clk source
    @(posedge clk);
    stoptimer <= 1'b1;
    apb_write(reg_addr(SLV_TMR, TMR_CFG_OFFS), 32'h1);
    apb_read(reg_addr(SLV_TMR, TMR_COUNT_OFFS));
    repeat (8) @(posedge clk);
    apb_read(reg_addr(SLV_TMR, TMR_COUNT_OFFS));
    apb_write(reg_addr(SLV_TMR, TMR_CMP_OFFS), 32'd20);
    apb_write(reg_addr(SLV_TMR, TMR_COUNT_OFFS), 32'h0);
    apb_write(reg_addr(SLV_TMR, TMR_CFG_OFFS), 32'h5);  // enable, clear on compare
    apb_read(reg_addr(SLV_TMR, TMR_CMP_OFFS));
    pulses0 = tmr_pulses;
    alt0    = tmr_alt_pulses;
    @(posedge clk);
    stoptimer <= 1'b0;
    while (tmr_pulses == pulses0) @(posedge clk);  // cycle limit catches a miss
    @(posedge clk);  // watcher counts on the negedge before
    check_eq("timer pulses on bit 7", chk_t'(tmr_pulses - pulses0), 33'h1);
    check_eq("timer pulses on bit 16", chk_t'(tmr_alt_pulses - alt0), 33'h1);
  endtask

  task automatic soft_reset_periph();
    pdata_t rnd;
    rnd = $random(seed);
    apb_write(reg_addr(SLV_GPIO, GPIO_DIR_OFFS), rnd | 32'h1);
    rnd = $random(seed);
    apb_write(reg_addr(SLV_GPIO, GPIO_OUT_OFFS), rnd);
    pins_match_shadow();
    apb_write(reg_addr(SLV_CTRL, CTRL_SOFT_RST_OFFS), 32'h1);
    pins_match_shadow();  // oe and out back at 0
    apb_read(reg_addr(SLV_GPIO, GPIO_DIR_OFFS));
    apb_read(reg_addr(SLV_GPIO, GPIO_OUT_OFFS));
    apb_read(reg_addr(SLV_GPIO, GPIO_IRQ_EN_OFFS));
    apb_read(reg_addr(SLV_GPIO, GPIO_IN_OFFS));  // resynced by now
    apb_read(reg_addr(SLV_TMR, TMR_CFG_OFFS));
    apb_read(reg_addr(SLV_TMR, TMR_COUNT_OFFS));
    apb_read(reg_addr(SLV_TMR, TMR_CMP_OFFS));
    apb_read(reg_addr(SLV_CTRL, CTRL_BOOTADDR_OFFS));
    apb_read(reg_addr(SLV_CTRL, CTRL_FETCHEN_OFFS));
  endtask

  initial begin : main
    rst_n     = 1'b0;
    ref_clk   = 1'b0;
    stoptimer = 1'b0;
    apb_req   = '0;
    apbio_in  = '0;
    clear_periph_shadow();
    sh_boot    = BOOT_ADDR_RST;
    sh_fetchen = 1'b0;
    sh_in      = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    pins_match_shadow();
    check_eq("fc_events_o after reset", chk_t'(fc_events), '0);
    boot_ctrl_readback();
    unmapped_access();
    gpio_pin_io();
    gpio_edge_irq();
    timer_ref_and_cmp();
    soft_reset_periph();
    repeat (2) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/apb_gpio.sv
// inputs may be fully async; pulses shorter than two clk_i cycles can be missed
// IRQ_STATUS is sticky and clears on read, writes to IN and IRQ_STATUS are dropped
`default_nettype none

module apb_gpio #(
  parameter int unsigned N_GPIO = 16  // 1 .. 32
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  logic [N_GPIO-1:0]        gpio_in_i,
  output logic [N_GPIO-1:0]        gpio_out_o,
  output logic [N_GPIO-1:0]        gpio_dir_o,  // 1 = drive the pad
  output logic                     irq_o
);

  import soc_periph_pkg::*;

  logic [N_GPIO-1:0] dir_q;
  logic [N_GPIO-1:0] out_q;
  logic [N_GPIO-1:0] irq_en_q;
  logic [N_GPIO-1:0] irq_status_q;
  logic [N_GPIO-1:0] sync0_q;  // first sync stage
  logic [N_GPIO-1:0] sync1_q;  // what IN returns
  logic [N_GPIO-1:0] prev_q;   // sync1 one cycle late
  logic [N_GPIO-1:0] rise;
  logic [N_GPIO-1:0] irq_set;
  logic              wr_en;
  logic              rd_en;
  reg_offs_t         offs;
  pdata_t            rdata;

  // access phase only, setup cycle does nothing
  assign offs  = apb_req_i.paddr[SLV_SEL_LSB-1:0];
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign rd_en = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

  //////////////////////////////////////////////////
  // input synchronizer and edge detect
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync0_q <= '0;
      sync1_q <= '0;
      prev_q  <= '0;
    end else begin
      sync0_q <= gpio_in_i;
      sync1_q <= sync0_q;
      prev_q  <= sync1_q;
    end
  end

  assign rise    = sync1_q & ~prev_q;
  assign irq_set = rise & irq_en_q;  // masked pins never reach status

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q        <= '0;
      out_q        <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
    end else begin
      if (wr_en && offs == GPIO_DIR_OFFS)    dir_q    <= apb_req_i.pwdata[N_GPIO-1:0];
      if (wr_en && offs == GPIO_OUT_OFFS)    out_q    <= apb_req_i.pwdata[N_GPIO-1:0];
      if (wr_en && offs == GPIO_IRQ_EN_OFFS) irq_en_q <= apb_req_i.pwdata[N_GPIO-1:0];
      // clear on read, an edge in the same cycle survives
      if (rd_en && offs == GPIO_IRQ_STATUS_OFFS) begin
        irq_status_q <= irq_set;
      end else begin
        irq_status_q <= irq_status_q | irq_set;
      end
    end
  end

  // read mux, narrow fields zero extended
  always_comb begin
    rdata = '0;
    case (offs)
      GPIO_DIR_OFFS:        rdata[N_GPIO-1:0] = dir_q;
      GPIO_OUT_OFFS:        rdata[N_GPIO-1:0] = out_q;
      GPIO_IN_OFFS:         rdata[N_GPIO-1:0] = sync1_q;
      GPIO_IRQ_EN_OFFS:     rdata[N_GPIO-1:0] = irq_en_q;
      GPIO_IRQ_STATUS_OFFS: rdata[N_GPIO-1:0] = irq_status_q;
      default:              rdata = '0;
    endcase
  end

  assign apb_rsp_o  = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;
  assign irq_o      = |irq_status_q;

  // newly set status bits must belong to pins enabled one cycle earlier
  a_status_enabled : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (irq_status_q & ~$past(irq_status_q) & ~$past(irq_en_q)) == '0);

endmodule

`default_nettype wire

//--- src/apb_periph_demux.sv
// purely combinational; paddr bits above the slave index are not decoded
`default_nettype none

module apb_periph_demux (
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  // per slave request side
  output soc_periph_pkg::apb_req_t gpio_req_o,
  output soc_periph_pkg::apb_req_t tmr_req_o,
  output soc_periph_pkg::apb_req_t ctrl_req_o,
  // per slave response side
  input  soc_periph_pkg::apb_rsp_t gpio_rsp_i,
  input  soc_periph_pkg::apb_rsp_t tmr_rsp_i,
  input  soc_periph_pkg::apb_rsp_t ctrl_rsp_i
);

  import soc_periph_pkg::*;

  slv_idx_t slv_idx;  // which 4 KiB window

  assign slv_idx = apb_req_i.paddr[SLV_SEL_LSB +: $bits(slv_idx_t)];

  //////////////////////////////////////////////////
  // request fan out
  //////////////////////////////////////////////////
  always_comb begin
    // address, data and strobes go everywhere
    gpio_req_o = apb_req_i;
    tmr_req_o  = apb_req_i;
    ctrl_req_o = apb_req_i;
    // only the addressed slave gets psel
    gpio_req_o.psel = apb_req_i.psel & (slv_idx == SLV_GPIO);
    tmr_req_o.psel  = apb_req_i.psel & (slv_idx == SLV_TMR);
    ctrl_req_o.psel = apb_req_i.psel & (slv_idx == SLV_CTRL);
  end

  //////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////
  always_comb begin
    case (slv_idx)
      SLV_GPIO: apb_rsp_o = gpio_rsp_i;
      SLV_TMR:  apb_rsp_o = tmr_rsp_i;
      SLV_CTRL: apb_rsp_o = ctrl_rsp_i;
      default:  apb_rsp_o = APB_RSP_ERR;  // index 3, error with zero data
    endcase
  end

endmodule

`default_nettype wire

//--- src/apb_soc_ctrl.sv
// periph_rst_n_o releases synchronously to clk_i; these registers see rst_n_i only
`default_nettype none

module apb_soc_ctrl #(
  parameter int unsigned N_GPIO = 16  // reported in INFO
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output soc_periph_pkg::paddr_t   fc_bootaddr_o,
  output logic                     fc_fetchen_o,
  output logic                     periph_rst_n_o  // for gpio and timer
);

  import soc_periph_pkg::*;

  paddr_t    bootaddr_q;
  logic      fetchen_q;
  logic      periph_rst_n_q;
  logic      soft_rst_req;  // write of 1 to SOFT_RST bit0
  logic      wr_en;
  reg_offs_t offs;
  pdata_t    rdata;

  assign offs  = apb_req_i.paddr[SLV_SEL_LSB-1:0];
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  assign soft_rst_req = wr_en & (offs == CTRL_SOFT_RST_OFFS) & apb_req_i.pwdata[0];

  //////////////////////////////////////////////////
  // boot control and soft reset
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bootaddr_q     <= BOOT_ADDR_RST;
      fetchen_q      <= 1'b0;
      periph_rst_n_q <= 1'b0;  // peripherals held while rst_n_i is low
    end else begin
      if (wr_en && offs == CTRL_BOOTADDR_OFFS) bootaddr_q <= apb_req_i.pwdata;
      if (wr_en && offs == CTRL_FETCHEN_OFFS)  fetchen_q  <= apb_req_i.pwdata[0];
      // low for the single cycle after the write, then back high
      periph_rst_n_q <= ~soft_rst_req;
    end
  end

  // INFO packs version over pin count; SOFT_RST reads 0
  always_comb begin
    rdata = '0;
    case (offs)
      CTRL_BOOTADDR_OFFS: rdata = bootaddr_q;
      CTRL_FETCHEN_OFFS:  rdata[0] = fetchen_q;
      CTRL_INFO_OFFS: begin
        rdata[15:8] = SOC_VERSION;
        rdata[7:0]  = 8'(N_GPIO);
      end
      default:            rdata = '0;
    endcase
  end

  assign apb_rsp_o      = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
  assign fc_bootaddr_o  = bootaddr_q;
  assign fc_fetchen_o   = fetchen_q;
  assign periph_rst_n_o = periph_rst_n_q;

endmodule

`default_nettype wire

//--- src/apb_timer_unit.sv
// ref_rise_i must already be a one-cycle pulse in the clk_i domain
// back-to-back matches, e.g. CMP 0 with clear-on-compare, are not supported
`default_nettype none

module apb_timer_unit (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     ref_rise_i,   // from the edge sync
  input  logic                     stoptimer_i,  // debug freeze
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output logic                     irq_o
);

  import soc_periph_pkg::*;

  tmr_cfg_t  cfg_q;
  pdata_t    count_q;
  pdata_t    cmp_q;
  logic      irq_q;
  logic      tick;  // count enable this cycle
  logic      hit;   // compare match on a tick
  logic      wr_en;
  reg_offs_t offs;
  pdata_t    rdata;

  assign offs  = apb_req_i.paddr[SLV_SEL_LSB-1:0];
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  //////////////////////////////////////////////////
  // tick source and compare
  //////////////////////////////////////////////////
  assign tick = cfg_q.en & ~stoptimer_i & (cfg_q.src_ref ? ref_rise_i : 1'b1);
  assign hit  = tick & (count_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q   <= '0;
      count_q <= '0;
      cmp_q   <= '0;
      irq_q   <= 1'b0;
    end else begin
      irq_q <= hit;  // pulse in the cycle after the match
      if (wr_en && offs == TMR_CFG_OFFS) begin
        cfg_q <= tmr_cfg_t'(apb_req_i.pwdata[$bits(tmr_cfg_t)-1:0]);
      end
      if (wr_en && offs == TMR_CMP_OFFS) cmp_q <= apb_req_i.pwdata;
      // bus load wins over counting
      if (wr_en && offs == TMR_COUNT_OFFS) begin
        count_q <= apb_req_i.pwdata;
      end else if (hit && cfg_q.clr_on_cmp) begin
        count_q <= '0;  // wrap at the matching tick
      end else if (tick) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // read side
  always_comb begin
    rdata = '0;
    case (offs)
      TMR_CFG_OFFS:   rdata[$bits(tmr_cfg_t)-1:0] = cfg_q;
      TMR_COUNT_OFFS: rdata = count_q;
      TMR_CMP_OFFS:   rdata = cmp_q;
      default:        rdata = '0;
    endcase
  end

  assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
  assign irq_o     = irq_q;

  a_irq_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o |=> !irq_o);

endmodule

`default_nettype wire

//--- src/ref_clk_edge_sync.sv
// ref_clk_i must stay at each level for at least two clk_i cycles or edges are lost
`default_nettype none

module ref_clk_edge_sync (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic ref_clk_i,  // async, slow
  output logic rise_o,
  output logic fall_o
);

  logic [1:0] sync_q;  // two stage synchronizer
  logic       level_q;  // previous synced level
  logic       rise_q;
  logic       fall_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q  <= '0;
      level_q <= 1'b0;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], ref_clk_i};
      level_q <= sync_q[1];
      rise_q  <= sync_q[1] & ~level_q;  // registered pulse, 3 cycles after the edge
      fall_q  <= ~sync_q[1] & level_q;
    end
  end

  assign rise_o = rise_q;
  assign fall_o = fall_q;

  a_no_double_edge : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rise_o && fall_o));

endmodule

`default_nettype wire

//--- src/soc_periph_pkg.sv
// slaves decode the low 12 address bits only, so each window is 4 KiB and word aligned
// pin count N_GPIO is a module parameter and lives outside this package
`default_nettype none

package soc_periph_pkg;

  // bus widths
  localparam int unsigned APB_ADDR_W = 32;
  localparam int unsigned APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] paddr_t;  // byte address
  typedef logic [APB_DATA_W-1:0] pdata_t;  // one bus word

  // request towards a slave, 67 bits
  typedef struct packed {
    paddr_t paddr;
    pdata_t pwdata;
    logic   pwrite;
    logic   psel;
    logic   penable;
  } apb_req_t;

  // response back to the master, 34 bits
  typedef struct packed {
    pdata_t prdata;
    logic   pready;
    logic   pslverr;
  } apb_rsp_t;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////
  localparam int unsigned SLV_SEL_LSB = 12;
  typedef logic [1:0] slv_idx_t;
  localparam slv_idx_t SLV_GPIO = 2'd0;
  localparam slv_idx_t SLV_TMR  = 2'd1;
  localparam slv_idx_t SLV_CTRL = 2'd2;  // index 3 is a hole

  typedef logic [SLV_SEL_LSB-1:0] reg_offs_t;  // offset inside one window

  // gpio registers
  localparam reg_offs_t GPIO_DIR_OFFS        = 12'h000;
  localparam reg_offs_t GPIO_OUT_OFFS        = 12'h004;
  localparam reg_offs_t GPIO_IN_OFFS         = 12'h008;
  localparam reg_offs_t GPIO_IRQ_EN_OFFS     = 12'h00C;
  localparam reg_offs_t GPIO_IRQ_STATUS_OFFS = 12'h010;

  // timer registers
  localparam reg_offs_t TMR_CFG_OFFS   = 12'h000;
  localparam reg_offs_t TMR_COUNT_OFFS = 12'h004;
  localparam reg_offs_t TMR_CMP_OFFS   = 12'h008;

  // CFG layout, bit0 at the bottom
  typedef struct packed {
    logic clr_on_cmp;  // bit2
    logic src_ref;     // bit1, count ref clock rises
    logic en;          // bit0
  } tmr_cfg_t;

  // soc control registers
  localparam reg_offs_t CTRL_BOOTADDR_OFFS = 12'h000;
  localparam reg_offs_t CTRL_FETCHEN_OFFS  = 12'h004;
  localparam reg_offs_t CTRL_INFO_OFFS     = 12'h008;
  localparam reg_offs_t CTRL_SOFT_RST_OFFS = 12'h00C;

  localparam paddr_t     BOOT_ADDR_RST = 32'h1A00_0080;
  localparam logic [7:0] SOC_VERSION   = 8'h02;

  // fc_events_o bit positions
  localparam int unsigned FC_EVT_TIMER_LO     = 7;   // mtime line
  localparam int unsigned FC_EVT_TIMER_LO_ALT = 16;  // same event, second slot
  localparam int unsigned FC_EVT_REF_RISE     = 18;
  localparam int unsigned FC_EVT_REF_FALL     = 19;
  localparam int unsigned FC_EVT_GPIO         = 20;

  // answer for the unmapped window
  localparam apb_rsp_t APB_RSP_ERR = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};

endpackage

`default_nettype wire

//--- src/soc_peripherals.sv
// single clock domain except ref_clk_i; event bits not listed in the package read 0
`default_nettype none

module soc_peripherals #(
  parameter int unsigned N_GPIO = 16  // 1 .. 32
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     ref_clk_i,
  input  logic                     stoptimer_i,
  // fabric controller bus
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  // pads
  input  logic [N_GPIO-1:0]        apbio_in_i,
  output logic [N_GPIO-1:0]        apbio_out_o,
  output logic [N_GPIO-1:0]        apbio_oe_o,
  // to the fabric controller core
  output soc_periph_pkg::paddr_t   fc_bootaddr_o,
  output logic                     fc_fetchen_o,
  output soc_periph_pkg::pdata_t   fc_events_o
);

  import soc_periph_pkg::*;

  apb_req_t gpio_req;
  apb_req_t tmr_req;
  apb_req_t ctrl_req;
  apb_rsp_t gpio_rsp;
  apb_rsp_t tmr_rsp;
  apb_rsp_t ctrl_rsp;
  logic     periph_rst_n;  // rst_n_i or soft reset
  logic     ref_rise;
  logic     ref_fall;
  logic     gpio_irq;
  logic     tmr_irq;

  //////////////////////////////////////////////////
  // bus split
  //////////////////////////////////////////////////
  apb_periph_demux u_apb_periph_demux (
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .gpio_req_o (gpio_req),
    .tmr_req_o  (tmr_req),
    .ctrl_req_o (ctrl_req),
    .gpio_rsp_i (gpio_rsp),
    .tmr_rsp_i  (tmr_rsp),
    .ctrl_rsp_i (ctrl_rsp)
  );

  // ref clock edges, also exported as events
  ref_clk_edge_sync u_ref_clk_edge_sync (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ref_clk_i (ref_clk_i),
    .rise_o    (ref_rise),
    .fall_o    (ref_fall)
  );

  //////////////////////////////////////////////////
  // peripherals
  //////////////////////////////////////////////////
  apb_gpio #(
    .N_GPIO (N_GPIO)
  ) u_apb_gpio (
    .clk_i      (clk_i),
    .rst_n_i    (periph_rst_n),
    .apb_req_i  (gpio_req),
    .apb_rsp_o  (gpio_rsp),
    .gpio_in_i  (apbio_in_i),
    .gpio_out_o (apbio_out_o),
    .gpio_dir_o (apbio_oe_o),
    .irq_o      (gpio_irq)
  );

  apb_timer_unit u_apb_timer_unit (
    .clk_i       (clk_i),
    .rst_n_i     (periph_rst_n),
    .ref_rise_i  (ref_rise),
    .stoptimer_i (stoptimer_i),
    .apb_req_i   (tmr_req),
    .apb_rsp_o   (tmr_rsp),
    .irq_o       (tmr_irq)
  );

  apb_soc_ctrl #(
    .N_GPIO (N_GPIO)
  ) u_apb_soc_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),  // survives its own soft reset
    .apb_req_i      (ctrl_req),
    .apb_rsp_o      (ctrl_rsp),
    .fc_bootaddr_o  (fc_bootaddr_o),
    .fc_fetchen_o   (fc_fetchen_o),
    .periph_rst_n_o (periph_rst_n)
  );

  // event vector, timer shows up twice
  always_comb begin
    fc_events_o                      = '0;
    fc_events_o[FC_EVT_TIMER_LO]     = tmr_irq;
    fc_events_o[FC_EVT_TIMER_LO_ALT] = tmr_irq;
    fc_events_o[FC_EVT_REF_RISE]     = ref_rise;
    fc_events_o[FC_EVT_REF_FALL]     = ref_fall;
    fc_events_o[FC_EVT_GPIO]         = gpio_irq;  // level, not a pulse
  end

endmodule

`default_nettype wire
